/* verilog.f */
+incdir+bench
source/calc_pkg.sv
source/timing_chain.sv
source/keyboard_scanner.sv
source/delay_line_store.sv
source/johnson_digit_holder.sv
source/bcd_serial_adder.sv
source/sequence_control.sv
source/ec130_calc_top.sv
bench/calc_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the calculator testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module calc_tb -f verilog.f -o calc_sim

./obj_dir/calc_sim > sim.log 2>&1
cat sim.log

if grep -q "STATUS: FAIL" sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi

echo "simulation finished without failures"

/* bench/calc_vectors.svh */
// Calculator key sequence and expected registers
// columns: name, key, hold cycles after ack, entry, X, Y (column 15 in top nibble), overflow

task automatic load_vectors();
    add_step("digit 1", KEY_1, 0, 64'h1, 64'h0, 64'h0, 1'b0);
    add_step("digit 2", KEY_2, 5, 64'h12, 64'h0, 64'h0, 1'b0);
    add_step("digit 3", KEY_3, 40, 64'h123, 64'h0, 64'h0, 1'b0);
    add_step("enter 123", KEY_ENTER, 0, 64'h0, 64'h123, 64'h0, 1'b0);
    add_step("digit 4", KEY_4, 0, 64'h4, 64'h123, 64'h0, 1'b0);
    add_step("digit 5", KEY_5, 0, 64'h45, 64'h123, 64'h0, 1'b0);
    add_step("digit 6", KEY_6, 0, 64'h456, 64'h123, 64'h0, 1'b0);
    add_step("add 456", KEY_ADD, 10, 64'h0, 64'h579, 64'h0, 1'b0);
    add_step("digit 7", KEY_7, 0, 64'h7, 64'h579, 64'h0, 1'b0);
    add_step("enter 7", KEY_ENTER, 0, 64'h0, 64'h7, 64'h579, 1'b0);
    add_step("digit 8", KEY_8, 0, 64'h8, 64'h7, 64'h579, 1'b0);
    add_step("add 8", KEY_ADD, 0, 64'h0, 64'h15, 64'h579, 1'b0);
    // sixteen nines fill the entry register
    add_step("nine 1", KEY_9, 0, 64'h9, 64'h15, 64'h579, 1'b0);
    add_step("nine 2", KEY_9, 0, 64'h99, 64'h15, 64'h579, 1'b0);
    add_step("nine 3", KEY_9, 0, 64'h999, 64'h15, 64'h579, 1'b0);
    add_step("nine 4", KEY_9, 0, 64'h9999, 64'h15, 64'h579, 1'b0);
    add_step("nine 5", KEY_9, 0, 64'h99999, 64'h15, 64'h579, 1'b0);
    add_step("nine 6", KEY_9, 0, 64'h999999, 64'h15, 64'h579, 1'b0);
    add_step("nine 7", KEY_9, 0, 64'h9999999, 64'h15, 64'h579, 1'b0);
    add_step("nine 8", KEY_9, 0, 64'h99999999, 64'h15, 64'h579, 1'b0);
    add_step("nine 9", KEY_9, 0, 64'h999999999, 64'h15, 64'h579, 1'b0);
    add_step("nine 10", KEY_9, 0, 64'h9999999999, 64'h15, 64'h579, 1'b0);
    add_step("nine 11", KEY_9, 0, 64'h99999999999, 64'h15, 64'h579, 1'b0);
    add_step("nine 12", KEY_9, 0, 64'h999999999999, 64'h15, 64'h579, 1'b0);
    add_step("nine 13", KEY_9, 0, 64'h9999999999999, 64'h15, 64'h579, 1'b0);
    add_step("nine 14", KEY_9, 0, 64'h99999999999999, 64'h15, 64'h579, 1'b0);
    add_step("nine 15", KEY_9, 0, 64'h999999999999999, 64'h15, 64'h579, 1'b0);
    add_step("nine 16", KEY_9, 0, 64'h9999999999999999, 64'h15, 64'h579, 1'b0);
    add_step("enter nines", KEY_ENTER, 0, 64'h0, 64'h9999999999999999, 64'h15, 1'b0);
    add_step("digit 1 again", KEY_1, 0, 64'h1, 64'h9999999999999999, 64'h15, 1'b0);
    add_step("add overflow", KEY_ADD, 0, 64'h0, 64'h0, 64'h15, 1'b1);
    // keyboard stays locked, the digit is ignored
    add_step("digit locked", KEY_5, 0, 64'h0, 64'h0, 64'h15, 1'b1);
    add_step("clear overflow", KEY_CLR_ENT, 0, 64'h0, 64'h0, 64'h15, 1'b0);
    add_step("digit 4 again", KEY_4, 0, 64'h4, 64'h0, 64'h15, 1'b0);
    add_step("enter 4", KEY_ENTER, 0, 64'h0, 64'h4, 64'h0, 1'b0);
    add_step("digit 6 again", KEY_6, 0, 64'h6, 64'h4, 64'h0, 1'b0);
    add_step("enter 6", KEY_ENTER, 0, 64'h0, 64'h6, 64'h4, 1'b0);
    add_step("digit 2 again", KEY_2, 20, 64'h2, 64'h6, 64'h4, 1'b0);
    add_step("clear entry", KEY_CLR_ENT, 0, 64'h0, 64'h6, 64'h4, 1'b0);
    add_step("clear all", KEY_CLR_ALL, 0, 64'h0, 64'h0, 64'h0, 1'b0);
endtask

/* bench/calc_tb.sv */
// EC-130 calculator testbench
`timescale 1ns/1ps
`default_nettype none

module calc_tb;
    import calc_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int IN_DELAY = 1;
    localparam logic [31:0] SEED = 32'ha5a5_65d6;
    localparam int TIMEOUT_MARGIN = 500;
    // two revolutions always cover the wait for home plus one full pass
    localparam int SETTLE_LIMIT = 2 * DL_WORDS + 2;

    logic                clk;
    logic                reset;
    logic [NUM_KEYS-1:0] keys;
    logic                kbd_ack;
    logic                kbd_lock;
    logic                overflow;
    bcd_digit_t          digit;
    reg_index_t          digit_slot;
    col_index_t          digit_col;

    // step table, filled from calc_vectors.svh
    string       step_name [$];
    key_code_t   step_key [$];
    int          step_hold [$];
    logic [63:0] exp_entry [$];
    logic [63:0] exp_x [$];
    logic [63:0] exp_y [$];
    logic        exp_ovf [$];

    // one revolution rebuilt as registers, column 15 in the top nibble
    logic [63:0] seen [NUM_REGS];

    int error_count = 0;
    int check_count = 0;
    int ack_count = 0;
    int cycle_count = 0;
    int cycle_limit = 0;

    ec130_calc_top uut (
        .clk         (clk),
        .i_reset     (reset),
        .i_keys      (keys),
        .o_kbd_ack   (kbd_ack),
        .o_kbd_lock  (kbd_lock),
        .o_overflow  (overflow),
        .o_digit     (digit),
        .o_digit_slot(digit_slot),
        .o_digit_col (digit_col)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: no result after %0d cycles", cycle_count);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    task automatic add_step(input string name, input key_code_t key, input int hold,
            input logic [63:0] entry, input logic [63:0] x, input logic [63:0] y,
            input logic ovf);
        step_name.push_back(name);
        step_key.push_back(key);
        step_hold.push_back(hold);
        exp_entry.push_back(entry);
        exp_x.push_back(x);
        exp_y.push_back(y);
        exp_ovf.push_back(ovf);
    endtask

    `include "calc_vectors.svh"

    // advance one clock and land just after the edge
    task automatic tick();
        @(posedge clk);
        #IN_DELAY;
        if (kbd_ack) begin
            ack_count++;
        end
    endtask

    task automatic compare_value(input string name, input logic [63:0] expected,
            input logic [63:0] actual);
        check_count++;
        if (expected !== actual) begin
            error_count++;
            $display("mismatch %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic capture_revolution();
        for (int r = 0; r < NUM_REGS; r++) begin
            seen[r] = '1;
        end
        for (int n = 0; n < DL_WORDS; n++) begin
            seen[digit_slot][int'(digit_col) * 4 +: 4] = digit;
            tick();
        end
    endtask

    task automatic check_registers(input string name, input logic [63:0] entry,
            input logic [63:0] x, input logic [63:0] y, input logic ovf);
        compare_value({name, " entry"}, entry, seen[REG_ENTRY]);
        compare_value({name, " x"}, x, seen[REG_X]);
        compare_value({name, " y"}, y, seen[REG_Y]);
        // spare slot only recirculates, so it stays at its reset value
        compare_value({name, " spare"}, 64'd0, seen[REG_SPARE]);
        compare_value({name, " overflow"}, 64'(ovf), 64'(overflow));
    endtask

    initial begin
        int   span;
        int   gap;
        logic span_ok;

        void'($urandom(SEED));
        reset = 1'b1;
        keys = '0;
        load_vectors();
        cycle_limit = step_name.size() * (KEYBOARD_DELAY + 200) + TIMEOUT_MARGIN;

        repeat (3) @(posedge clk);
        #IN_DELAY;
        reset = 1'b0;

        compare_value("reset ack", 64'd0, 64'(kbd_ack));
        compare_value("reset lock", 64'd0, 64'(kbd_lock));
        capture_revolution();
        check_registers("reset", 64'd0, 64'd0, 64'd0, 1'b0);

        for (int i = 0; i < step_name.size(); i++) begin
            // vary where in the revolution the key lands
            gap = int'($urandom_range(3));
            repeat (gap) tick();

            ack_count = 0;
            keys[step_key[i]] = 1'b1;
            do begin
                tick();
            end while (!kbd_ack);

            span = 0;
            do begin
                if (span >= step_hold[i]) begin
                    keys = '0;
                end
                tick();
                span++;
            end while (kbd_lock && span < SETTLE_LIMIT);
            keys = '0;

            if (exp_ovf[i]) begin
                compare_value({step_name[i], " lock"}, 64'd1, 64'(kbd_lock));
            end else begin
                // lock covers the wait for home and one whole revolution
                span_ok = (span > DL_WORDS) && (span <= 2 * DL_WORDS);
                compare_value({step_name[i], " lock span"}, 64'd1, 64'(span_ok));
            end

            capture_revolution();
            compare_value({step_name[i], " acks"}, 64'd1, 64'(ack_count));
            check_registers(step_name[i], exp_entry[i], exp_x[i], exp_y[i], exp_ovf[i]);
        end

        $display("checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* source/ec130_calc_top.sv */
// EC-130 four-counter calculator
`timescale 1ns/1ps
`default_nettype none

module ec130_calc_top (
    input  wire                            clk,
    input  wire                            i_reset,
    input  wire [calc_pkg::NUM_KEYS-1:0]   i_keys,
    output logic                           o_kbd_ack,
    output logic                           o_kbd_lock,
    output logic                           o_overflow,
    output calc_pkg::bcd_digit_t           o_digit,
    output calc_pkg::reg_index_t           o_digit_slot,
    output calc_pkg::col_index_t           o_digit_col
);
    import calc_pkg::*;

    word_index_t word;
    reg_index_t  slot;
    col_index_t  col;
    logic        home;
    logic        busy;
    key_code_t   key;
    bcd_digit_t  rd_digit;
    bcd_digit_t  wr_digit;
    bcd_digit_t  held_entry;
    bcd_digit_t  held_x;
    bcd_digit_t  sum;
    logic        carry_out;
    logic        load_entry;
    logic        load_x;
    logic        add_start;
    logic        add_step;

    timing_chain u_timing (
        .clk    (clk),
        .i_reset(i_reset),
        .o_word (word),
        .o_slot (slot),
        .o_col  (col),
        .o_home (home)
    );

    keyboard_scanner u_keyboard (
        .clk      (clk),
        .i_reset  (i_reset),
        .i_keys   (i_keys),
        .i_busy   (busy),
        .o_kbd_ack(o_kbd_ack),
        .o_key    (key)
    );

    delay_line_store u_delay_line (
        .clk       (clk),
        .i_reset   (i_reset),
        .i_word    (word),
        .i_wr_digit(wr_digit),
        .o_rd_digit(rd_digit)
    );

    johnson_digit_holder u_hold_entry (
        .clk      (clk),
        .i_reset  (i_reset),
        .i_load   (load_entry),
        .i_digit  (rd_digit),
        .o_digit  (held_entry),
        .o_invalid()
    );

    johnson_digit_holder u_hold_x (
        .clk      (clk),
        .i_reset  (i_reset),
        .i_load   (load_x),
        .i_digit  (rd_digit),
        .o_digit  (held_x),
        .o_invalid()
    );

    // entry digit plus the X digit under the head
    bcd_serial_adder u_adder (
        .clk        (clk),
        .i_reset    (i_reset),
        .i_start    (add_start),
        .i_step     (add_step),
        .i_a        (held_entry),
        .i_b        (rd_digit),
        .o_sum      (sum),
        .o_carry_out(carry_out)
    );

    sequence_control u_control (
        .clk         (clk),
        .i_reset     (i_reset),
        .i_kbd_ack   (o_kbd_ack),
        .i_key       (key),
        .i_home      (home),
        .i_slot      (slot),
        .i_col       (col),
        .i_rd_digit  (rd_digit),
        .i_held_entry(held_entry),
        .i_held_x    (held_x),
        .i_sum       (sum),
        .i_carry_out (carry_out),
        .o_busy      (busy),
        .o_kbd_lock  (o_kbd_lock),
        .o_overflow  (o_overflow),
        .o_load_entry(load_entry),
        .o_load_x    (load_x),
        .o_add_start (add_start),
        .o_add_step  (add_step),
        .o_wr_digit  (wr_digit)
    );

    // observation stream, one word every cycle
    assign o_digit = rd_digit;
    assign o_digit_slot = slot;
    assign o_digit_col = col;

endmodule

`default_nettype wire

/* source/sequence_control.sv */
// Operation sequencer and overflow control
`timescale 1ns/1ps
`default_nettype none

module sequence_control (
    input  wire                        clk,
    input  wire                        i_reset,
    input  wire                        i_kbd_ack,
    input  wire calc_pkg::key_code_t   i_key,
    input  wire                        i_home,
    input  wire calc_pkg::reg_index_t  i_slot,
    input  wire calc_pkg::col_index_t  i_col,
    input  wire calc_pkg::bcd_digit_t  i_rd_digit,
    input  wire calc_pkg::bcd_digit_t  i_held_entry,
    input  wire calc_pkg::bcd_digit_t  i_held_x,
    input  wire calc_pkg::bcd_digit_t  i_sum,
    input  wire                        i_carry_out,
    output logic                       o_busy,
    output logic                       o_kbd_lock,
    output logic                       o_overflow,
    output logic                       o_load_entry,
    output logic                       o_load_x,
    output logic                       o_add_start,
    output logic                       o_add_step,
    output calc_pkg::bcd_digit_t       o_wr_digit
);
    import calc_pkg::*;

    op_t        op;
    op_t        next_op;
    bcd_digit_t key_digit;
    logic       running;
    logic       write_en;
    logic       active;
    logic       last_word;

    function automatic op_t decode_op(input key_code_t key);
        op_t result;
        case (key)
            KEY_ENTER:   result = OP_ENTER;
            KEY_ADD:     result = OP_ADD;
            KEY_CLR_ENT: result = OP_CLR_ENT;
            KEY_CLR_ALL: result = OP_CLR_ALL;
            default:     result = OP_DIGIT;
        endcase
        return result;
    endfunction

    assign next_op = decode_op(i_key);

    // one full revolution starting at home
    assign active = o_busy && (running || i_home);
    assign last_word = active && (i_slot == REG_SPARE)
        && (i_col == col_index_t'(NUM_COLS - 1));

    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_busy <= 1'b0;
            running <= 1'b0;
            write_en <= 1'b0;
            o_overflow <= 1'b0;
        end else begin
            if (i_kbd_ack) begin
                o_busy <= 1'b1;
                running <= 1'b0;
                // with the overflow lamp lit only the clear keys do anything
                write_en <= !o_overflow || (next_op == OP_CLR_ENT) || (next_op == OP_CLR_ALL);
            end else if (last_word) begin
                o_busy <= 1'b0;
                running <= 1'b0;
            end else if (active) begin
                running <= 1'b1;
            end

            if (last_word && write_en) begin
                case (op)
                    OP_ADD: begin
                        if (i_carry_out) begin
                            o_overflow <= 1'b1;
                        end
                    end
                    OP_CLR_ENT, OP_CLR_ALL: o_overflow <= 1'b0;
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_kbd_ack) begin
            op <= next_op;
            key_digit <= bcd_digit_t'(i_key);
        end
    end

    assign o_kbd_lock = o_busy || o_overflow;

    // holders capture the digit passing under the head
    assign o_load_entry = active && (i_slot == REG_ENTRY);
    assign o_load_x = active && (i_slot == REG_X);
    assign o_add_start = active && i_home;
    assign o_add_step = active && write_en && (op == OP_ADD) && (i_slot == REG_X);

    // write-back, recirculates unless the op changes this slot
    always_comb begin
        o_wr_digit = i_rd_digit;
        if (active && write_en) begin
            case (op)
                OP_DIGIT: begin
                    // holder still shows the entry digit one column down
                    if (i_slot == REG_ENTRY) begin
                        o_wr_digit = (i_col == '0) ? key_digit : i_held_entry;
                    end
                end
                OP_ENTER: begin
                    case (i_slot)
                        REG_ENTRY: o_wr_digit = '0;
                        REG_X:     o_wr_digit = i_held_entry;
                        REG_Y:     o_wr_digit = i_held_x;
                        default:   ;
                    endcase
                end
                OP_ADD: begin
                    case (i_slot)
                        REG_ENTRY: o_wr_digit = '0;
                        REG_X:     o_wr_digit = i_sum;
                        default:   ;
                    endcase
                end
                OP_CLR_ENT: begin
                    if (i_slot == REG_ENTRY) begin
                        o_wr_digit = '0;
                    end
                end
                OP_CLR_ALL: o_wr_digit = '0;
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

/* source/bcd_serial_adder.sv */
// Digit serial BCD adder
`timescale 1ns/1ps
`default_nettype none

module bcd_serial_adder (
    input  wire                        clk,
    input  wire                        i_reset,
    input  wire                        i_start,
    input  wire                        i_step,
    input  wire calc_pkg::bcd_digit_t  i_a,
    input  wire calc_pkg::bcd_digit_t  i_b,
    output calc_pkg::bcd_digit_t       o_sum,
    output logic                       o_carry_out
);
    import calc_pkg::*;

    logic       carry;
    logic [4:0] raw;
    logic       digit_carry;

    // binary sum of two digits and the carry, at most 19
    assign raw = {1'b0, i_a} + {1'b0, i_b} + {4'b0000, carry};
    assign digit_carry = (raw > 5'd9);

    // decimal correction
    assign o_sum = digit_carry ? bcd_digit_t'(raw - 5'd10) : raw[3:0];

    // carry travels to the next column, one step per digit
    always_ff @(posedge clk) begin
        if (i_reset || i_start) begin
            carry <= 1'b0;
        end else if (i_step) begin
            carry <= digit_carry;
        end
    end

    assign o_carry_out = carry;

endmodule

`default_nettype wire

/* source/johnson_digit_holder.sv */
// Johnson ring counter digit holder
`timescale 1ns/1ps
`default_nettype none

module johnson_digit_holder (
    input  wire                        clk,
    input  wire                        i_reset,
    input  wire                        i_load,
    input  wire calc_pkg::bcd_digit_t  i_digit,
    output calc_pkg::bcd_digit_t       o_digit,
    output logic                       o_invalid
);
    import calc_pkg::*;

    johnson_code_t code;

    function automatic johnson_code_t encode(input bcd_digit_t d);
        johnson_code_t c;
        case (d)
            4'd0:    c = 5'b00000;
            4'd1:    c = 5'b00001;
            4'd2:    c = 5'b00011;
            4'd3:    c = 5'b00111;
            4'd4:    c = 5'b01111;
            4'd5:    c = 5'b11111;
            4'd6:    c = 5'b11110;
            4'd7:    c = 5'b11100;
            4'd8:    c = 5'b11000;
            4'd9:    c = 5'b10000;
            // not a ring state, so it reads back as invalid
            default: c = 5'b01010;
        endcase
        return c;
    endfunction

    always_ff @(posedge clk) begin
        if (i_reset) begin
            code <= '0;
        end else if (i_load) begin
            code <= encode(i_digit);
        end
    end

    always_comb begin
        o_invalid = 1'b0;
        case (code)
            5'b00000: o_digit = 4'd0;
            5'b00001: o_digit = 4'd1;
            5'b00011: o_digit = 4'd2;
            5'b00111: o_digit = 4'd3;
            5'b01111: o_digit = 4'd4;
            5'b11111: o_digit = 4'd5;
            5'b11110: o_digit = 4'd6;
            5'b11100: o_digit = 4'd7;
            5'b11000: o_digit = 4'd8;
            5'b10000: o_digit = 4'd9;
            default: begin
                o_digit = 4'hf;
                o_invalid = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

/* source/delay_line_store.sv */
// Recirculating digit store
`timescale 1ns/1ps
`default_nettype none

module delay_line_store (
    input  wire                        clk,
    input  wire                        i_reset,
    input  wire calc_pkg::word_index_t i_word,
    input  wire calc_pkg::bcd_digit_t  i_wr_digit,
    output calc_pkg::bcd_digit_t       o_rd_digit
);
    import calc_pkg::*;

    bcd_digit_t mem [DL_WORDS];

    // the word under the read head this cycle
    assign o_rd_digit = mem[i_word];

    // every word is rewritten as it passes, so it comes back one revolution later
    always_ff @(posedge clk) begin
        if (i_reset) begin
            for (int w = 0; w < DL_WORDS; w++) begin
                mem[w] <= '0;
            end
        end else begin
            mem[i_word] <= i_wr_digit;
        end
    end

endmodule

`default_nettype wire

/* source/keyboard_scanner.sv */
// Keyboard delay and key encoder
`timescale 1ns/1ps
`default_nettype none

module keyboard_scanner (
    input  wire                            clk,
    input  wire                            i_reset,
    input  wire [calc_pkg::NUM_KEYS-1:0]   i_keys,
    input  wire                            i_busy,
    output logic                           o_kbd_ack,
    output calc_pkg::key_code_t            o_key
);
    import calc_pkg::*;

    logic [KBD_CNT_W-1:0] count;
    logic                 any_key;
    logic                 at_limit;
    logic                 count_up;
    key_code_t            enc;

    assign any_key = |i_keys;
    assign at_limit = (count == KBD_CNT_W'(KEYBOARD_DELAY - 1));

    // a held key only counts while the machine is idle
    assign count_up = any_key && !i_busy && !at_limit;

    // lowest key index wins
    always_comb begin
        enc = '0;
        for (int k = NUM_KEYS - 1; k >= 0; k--) begin
            if (i_keys[k]) begin
                enc = key_code_t'(k);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            count <= '0;
            o_kbd_ack <= 1'b0;
        end else begin
            o_kbd_ack <= count_up && (count == KBD_CNT_W'(KEYBOARD_DELAY - 2));
            if (!any_key) begin
                count <= '0;
            end else if (count_up) begin
                count <= count + 1'b1;
            end
        end
    end

    // key code is valid alongside the ack pulse
    always_ff @(posedge clk) begin
        if (count_up && (count == KBD_CNT_W'(KEYBOARD_DELAY - 2))) begin
            o_key <= enc;
        end
    end

endmodule

`default_nettype wire

/* source/timing_chain.sv */
// Delay line timing chain
`timescale 1ns/1ps
`default_nettype none

module timing_chain (
    input  wire                        clk,
    input  wire                        i_reset,
    output calc_pkg::word_index_t      o_word,
    output calc_pkg::reg_index_t       o_slot,
    output calc_pkg::col_index_t       o_col,
    output logic                       o_home
);
    import calc_pkg::*;

    // one word per clock, wraps after a full revolution
    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_word <= '0;
        end else if (o_word == word_index_t'(DL_WORDS - 1)) begin
            o_word <= '0;
        end else begin
            o_word <= o_word + 1'b1;
        end
    end

    // low bits pick the register, high bits the digit column
    assign o_slot = o_word[$bits(reg_index_t)-1:0];
    assign o_col = o_word[$bits(word_index_t)-1:$bits(reg_index_t)];

    assign o_home = (o_word == '0);

endmodule

`default_nettype wire

/* source/calc_pkg.sv */
// EC-130 calculator shared definitions
`default_nettype none

package calc_pkg;

    // delay line geometry, digits interleaved by column
    localparam int NUM_REGS = 4;
    localparam int NUM_COLS = 16;
    localparam int DL_WORDS = NUM_REGS * NUM_COLS;

    localparam int KEYBOARD_DELAY = 100;
    localparam int KBD_CNT_W = $clog2(KEYBOARD_DELAY);
    localparam int NUM_KEYS = 14;

    typedef logic [3:0] bcd_digit_t;
    typedef logic [4:0] johnson_code_t;
    typedef logic [$clog2(NUM_REGS)-1:0] reg_index_t;
    typedef logic [$clog2(NUM_COLS)-1:0] col_index_t;
    typedef logic [$clog2(DL_WORDS)-1:0] word_index_t;
    typedef logic [3:0] key_code_t;

    // key positions, digit keys first so the code is the digit value
    localparam key_code_t KEY_0 = 4'd0;
    localparam key_code_t KEY_1 = 4'd1;
    localparam key_code_t KEY_2 = 4'd2;
    localparam key_code_t KEY_3 = 4'd3;
    localparam key_code_t KEY_4 = 4'd4;
    localparam key_code_t KEY_5 = 4'd5;
    localparam key_code_t KEY_6 = 4'd6;
    localparam key_code_t KEY_7 = 4'd7;
    localparam key_code_t KEY_8 = 4'd8;
    localparam key_code_t KEY_9 = 4'd9;
    localparam key_code_t KEY_ENTER = 4'd10;
    localparam key_code_t KEY_ADD = 4'd11;
    localparam key_code_t KEY_CLR_ENT = 4'd12;
    localparam key_code_t KEY_CLR_ALL = 4'd13;

    localparam reg_index_t REG_ENTRY = 2'd0;
    localparam reg_index_t REG_X = 2'd1;
    localparam reg_index_t REG_Y = 2'd2;
    localparam reg_index_t REG_SPARE = 2'd3;

    typedef enum logic [2:0] {
        OP_DIGIT,
        OP_ENTER,
        OP_ADD,
        OP_CLR_ENT,
        OP_CLR_ALL
    } op_t;

endpackage

`default_nettype wire
